/* cascadePkg.sv */
package cascadePkg;

  // signed fixed point for thresholds, alphas, sums and areas
  typedef logic signed [31:0] fixedT;

  // signed rectangle weight as stored in a rectangle word
  typedef logic signed [11:0] weightT;

  // coordinate inside the integral-image window
  typedef logic [4:0] coordT;

  typedef logic [7:0] stageCountT;
  typedef logic [7:0] classCountT;

  // fraction bits removed after threshold times normalization factor
  localparam int fracBitsDefault = 12;

  // rectangle word fields
  localparam int coordBits = 5;
  localparam int weightBits = 12;
  localparam int x0Lsb = 0;
  localparam int y0Lsb = 5;
  localparam int x1Lsb = 10;
  localparam int y1Lsb = 15;
  localparam int weightLsb = 20;

  // cascade layout in memory, one word each:
  //   header with the stage count
  //   per stage: stage threshold, classifier count
  //   per classifier: class threshold, rect 1, rect 2, fail alpha, pass alpha
  localparam int countBits = 8;

endpackage

/* busPkg.sv */
package busPkg;

  // word address on the shared read bus
  typedef logic [15:0] busAddrT;

  // read data returned by the memory
  typedef logic [31:0] busDataT;

  // index of a peer master on the arbiter
  typedef logic [0:0] masterIdT;

  localparam masterIdT seqId = 1'b0;
  localparam masterIdT smpId = 1'b1;

  // cascade words start here
  localparam busAddrT cascadeBaseDefault = 16'h0000;

  // integral image, corner (x,y) at windowBase + y * windowStride + x
  localparam busAddrT windowBaseDefault = 16'h8000;
  localparam int windowStrideDefault = 32;

endpackage

/* busArbiter.sv */
module busArbiter (
  input  logic             clk,
  input  logic             rstN,
  input  logic             seqCyc,
  input  logic             seqStb,
  input  busPkg::busAddrT  seqAdr,
  input  logic             smpCyc,
  input  logic             smpStb,
  input  busPkg::busAddrT  smpAdr,
  input  logic             ack,
  output logic             seqAck,
  output logic             smpAck,
  output logic             cyc,
  output logic             stb,
  output busPkg::busAddrT  adr
);

  import busPkg::*;

  logic     busy;
  masterIdT grantId;
  masterIdT lastServed;
  masterIdT pick;
  logic     grantCyc;
  logic     grantStb;

  assign grantCyc = (grantId == smpId) ? smpCyc : seqCyc;
  assign grantStb = (grantId == smpId) ? smpStb : seqStb;

  // on a tie the peer that was not served last wins
  always_comb begin
    if (seqCyc && smpCyc) begin
      pick = ~lastServed;
    end else if (smpCyc) begin
      pick = smpId;
    end else begin
      pick = seqId;
    end
  end

  // grant is kept while the granted peer holds cyc
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      busy <= 1'b0;
      grantId <= seqId;
      lastServed <= smpId;
    end else if (!busy || !grantCyc) begin
      if (seqCyc || smpCyc) begin
        busy <= 1'b1;
        grantId <= pick;
        lastServed <= pick;
      end else begin
        busy <= 1'b0;
      end
    end
  end

  assign cyc = busy && grantCyc;
  assign stb = busy && grantStb;
  assign adr = (grantId == smpId) ? smpAdr : seqAdr;

  // ack goes back only to the granted peer
  assign seqAck = ack && busy && (grantId == seqId);
  assign smpAck = ack && busy && (grantId == smpId);

endmodule

/* cascadeSequencer.sv */
module cascadeSequencer #(
  parameter busPkg::busAddrT cascadeBase = busPkg::cascadeBaseDefault
) (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 start,
  input  cascadePkg::fixedT    varNormIn,
  input  logic                 taken,
  input  logic                 busAck,
  input  busPkg::busDataT      busDat,
  input  logic                 areaValid,
  input  logic                 voteValid,
  input  logic                 votePass,
  output logic                 ready,
  output logic                 done,
  output logic                 passed,
  output logic                 busCyc,
  output logic                 busStb,
  output busPkg::busAddrT      busAdr,
  output logic                 rectStart,
  output cascadePkg::coordT    rect1X0,
  output cascadePkg::coordT    rect1Y0,
  output cascadePkg::coordT    rect1X1,
  output cascadePkg::coordT    rect1Y1,
  output cascadePkg::coordT    rect2X0,
  output cascadePkg::coordT    rect2Y0,
  output cascadePkg::coordT    rect2X1,
  output cascadePkg::coordT    rect2Y1,
  output cascadePkg::weightT   weight1,
  output cascadePkg::weightT   weight2,
  output cascadePkg::fixedT    classThreshold,
  output cascadePkg::fixedT    varNorm
);

  import cascadePkg::*;
  import busPkg::*;

  typedef enum logic [3:0] {
    idle, readHeader, readStageThr, readClassCount, readClassThr, readRect1,
    readRect2, readFailVote, readPassVote, waitVote, stageCheck, finish
  } stateT;

  stateT      state;
  busAddrT    cascadeAddr;
  stageCountT stagesLeft;
  classCountT classLeft;
  fixedT      stageThr;
  fixedT      stageSum;
  fixedT      failVote;
  fixedT      passVote;
  logic       reqActive;
  logic       readState;
  logic       acked;
  logic       scoring;
  logic       voteSeen;
  logic       voteResult;
  logic       voteNow;
  logic       passNow;

  assign readState = state inside {readHeader, readStageThr, readClassCount, readClassThr,
                                   readRect1, readRect2, readFailVote, readPassVote};
  assign acked = reqActive && busAck;

  assign busCyc = reqActive;
  assign busStb = reqActive;
  assign busAdr = cascadeAddr;
  assign ready = (state == idle);
  assign done = (state == finish);

  // the vote may land before the alpha words are in
  assign voteNow = voteSeen || (voteValid && scoring);
  assign passNow = voteSeen ? voteResult : votePass;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= idle;
      reqActive <= 1'b0;
      rectStart <= 1'b0;
      scoring <= 1'b0;
      voteSeen <= 1'b0;
      passed <= 1'b0;
      cascadeAddr <= '0;
      stagesLeft <= '0;
      classLeft <= '0;
      stageSum <= '0;
    end else begin
      rectStart <= 1'b0;
      // one read at a time, stb drops the cycle after ack
      if (reqActive) begin
        reqActive <= !busAck;
      end else begin
        reqActive <= readState;
      end
      if (acked) begin
        cascadeAddr <= cascadeAddr + 1'b1;
      end
      // a vote is expected only after the areas went out
      if (areaValid) begin
        scoring <= 1'b1;
      end else if (voteValid) begin
        scoring <= 1'b0;
      end
      if (state == waitVote && voteNow) begin
        voteSeen <= 1'b0;
      end else if (voteValid && scoring) begin
        voteSeen <= 1'b1;
      end
      case (state)
        idle: begin
          if (start) begin
            cascadeAddr <= cascadeBase;
            passed <= 1'b0;
            state <= readHeader;
          end
        end
        readHeader: begin
          if (acked) begin
            stagesLeft <= busDat[countBits-1:0];
            // an empty cascade accepts every window
            passed <= (busDat[countBits-1:0] == '0);
            state <= (busDat[countBits-1:0] == '0) ? finish : readStageThr;
          end
        end
        readStageThr: begin
          if (acked) begin
            stageSum <= '0;
            state <= readClassCount;
          end
        end
        readClassCount: begin
          if (acked) begin
            classLeft <= busDat[countBits-1:0];
            state <= (busDat[countBits-1:0] == '0) ? stageCheck : readClassThr;
          end
        end
        readClassThr: if (acked) state <= readRect1;
        readRect1: if (acked) state <= readRect2;
        readRect2: begin
          if (acked) begin
            rectStart <= 1'b1;
            state <= readFailVote;
          end
        end
        readFailVote: if (acked) state <= readPassVote;
        readPassVote: if (acked) state <= waitVote;
        waitVote: begin
          if (voteNow) begin
            stageSum <= stageSum + (passNow ? passVote : failVote);
            classLeft <= classLeft - 1'b1;
            state <= (classLeft == 8'd1) ? stageCheck : readClassThr;
          end
        end
        stageCheck: begin
          if (stageSum < stageThr) begin
            passed <= 1'b0;
            state <= finish;
          end else if (stagesLeft == 8'd1) begin
            passed <= 1'b1;
            state <= finish;
          end else begin
            stagesLeft <= stagesLeft - 1'b1;
            state <= readStageThr;
          end
        end
        finish: if (taken) state <= idle;
        default: state <= idle;
      endcase
    end
  end

  // captured cascade words
  always_ff @(posedge clk) begin
    if (state == idle && start) begin
      varNorm <= varNormIn;
    end
    if (voteValid) begin
      voteResult <= votePass;
    end
    if (acked) begin
      case (state)
        readStageThr: stageThr <= busDat;
        readClassThr: classThreshold <= busDat;
        readRect1: begin
          rect1X0 <= busDat[x0Lsb +: coordBits];
          rect1Y0 <= busDat[y0Lsb +: coordBits];
          rect1X1 <= busDat[x1Lsb +: coordBits];
          rect1Y1 <= busDat[y1Lsb +: coordBits];
          weight1 <= busDat[weightLsb +: weightBits];
        end
        readRect2: begin
          rect2X0 <= busDat[x0Lsb +: coordBits];
          rect2Y0 <= busDat[y0Lsb +: coordBits];
          rect2X1 <= busDat[x1Lsb +: coordBits];
          rect2Y1 <= busDat[y1Lsb +: coordBits];
          weight2 <= busDat[weightLsb +: weightBits];
        end
        readFailVote: failVote <= busDat;
        readPassVote: passVote <= busDat;
        default: ;
      endcase
    end
  end

endmodule

/* rectangleSampler.sv */
module rectangleSampler #(
  parameter busPkg::busAddrT windowBase = busPkg::windowBaseDefault,
  parameter int windowStride = busPkg::windowStrideDefault
) (
  input  logic               clk,
  input  logic               rstN,
  input  logic               rectStart,
  input  cascadePkg::coordT  rect1X0,
  input  cascadePkg::coordT  rect1Y0,
  input  cascadePkg::coordT  rect1X1,
  input  cascadePkg::coordT  rect1Y1,
  input  cascadePkg::coordT  rect2X0,
  input  cascadePkg::coordT  rect2Y0,
  input  cascadePkg::coordT  rect2X1,
  input  cascadePkg::coordT  rect2Y1,
  input  logic               busAck,
  input  busPkg::busDataT    busDat,
  output logic               busCyc,
  output logic               busStb,
  output busPkg::busAddrT    busAdr,
  output logic               areaValid,
  output cascadePkg::fixedT  area1,
  output cascadePkg::fixedT  area2
);

  import cascadePkg::*;
  import busPkg::*;

  logic       running;
  logic       reqActive;
  logic       acked;
  logic [2:0] corner;
  coordT      cornerX;
  coordT      cornerY;
  fixedT      sample;

  // corner[2] picks the rectangle, corner[1] picks x0, corner[0] picks y0
  // order per rectangle is (x1,y1) (x1,y0) (x0,y1) (x0,y0)
  // coordinates stay stable at the inputs until the vote is back
  always_comb begin
    if (corner[2]) begin
      cornerX = corner[1] ? rect2X0 : rect2X1;
      cornerY = corner[0] ? rect2Y0 : rect2Y1;
    end else begin
      cornerX = corner[1] ? rect1X0 : rect1X1;
      cornerY = corner[0] ? rect1Y0 : rect1Y1;
    end
  end

  assign busAdr = windowBase + busAddrT'(cornerY) * busAddrT'(windowStride)
                  + busAddrT'(cornerX);
  assign busCyc = reqActive;
  assign busStb = reqActive;
  assign acked = reqActive && busAck;

  // the two mixed corners are subtracted
  assign sample = (corner[1] ^ corner[0]) ? -fixedT'(busDat) : fixedT'(busDat);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      running <= 1'b0;
      reqActive <= 1'b0;
      corner <= '0;
      areaValid <= 1'b0;
    end else begin
      areaValid <= 1'b0;
      if (reqActive) begin
        reqActive <= !busAck;
      end else begin
        reqActive <= running || rectStart;
      end
      if (rectStart) begin
        running <= 1'b1;
        corner <= '0;
      end else if (acked) begin
        corner <= corner + 1'b1;
        if (corner == 3'd7) begin
          running <= 1'b0;
          areaValid <= 1'b1;
        end
      end
    end
  end

  // area accumulators, restarted on each rectangle's first corner
  always_ff @(posedge clk) begin
    if (acked) begin
      if (corner[2]) begin
        area2 <= (corner[1:0] == 2'd0) ? sample : area2 + sample;
      end else begin
        area1 <= (corner[1:0] == 2'd0) ? sample : area1 + sample;
      end
    end
  end

endmodule

/* classifierScorer.sv */
module classifierScorer #(
  parameter int fracBits = cascadePkg::fracBitsDefault
) (
  input  logic                clk,
  input  logic                rstN,
  input  logic                areaValid,
  input  cascadePkg::fixedT   area1,
  input  cascadePkg::fixedT   area2,
  input  cascadePkg::weightT  weight1,
  input  cascadePkg::weightT  weight2,
  input  cascadePkg::fixedT   classThreshold,
  input  cascadePkg::fixedT   varNorm,
  output logic                voteValid,
  output logic                votePass
);

  import cascadePkg::*;

  logic               sumValid;
  fixedT              weighted1;
  fixedT              weighted2;
  fixedT              featureSum;
  fixedT              normThreshold;
  logic signed [63:0] thrProduct;

  // weighted areas wrap at the fixed-point width
  assign weighted1 = fixedT'(weight1) * area1;
  assign weighted2 = fixedT'(weight2) * area2;
  assign thrProduct = 64'(classThreshold) * 64'(varNorm);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      sumValid <= 1'b0;
      voteValid <= 1'b0;
    end else begin
      sumValid <= areaValid;
      voteValid <= sumValid;
    end
  end

  always_ff @(posedge clk) begin
    // stage one, feature sum and scaled threshold
    if (areaValid) begin
      featureSum <= weighted1 + weighted2;
      normThreshold <= fixedT'(thrProduct >>> fracBits);
    end
    // stage two, compare
    if (sumValid) begin
      votePass <= (featureSum >= normThreshold);
    end
  end

endmodule

/* haarCascade.sv */
module haarCascade #(
  parameter busPkg::busAddrT cascadeBase = busPkg::cascadeBaseDefault,
  parameter busPkg::busAddrT windowBase = busPkg::windowBaseDefault,
  parameter int windowStride = busPkg::windowStrideDefault,
  parameter int fracBits = cascadePkg::fracBitsDefault
) (
  input  logic               clk,
  input  logic               rstN,
  input  logic               start,
  input  cascadePkg::fixedT  varNorm,
  input  logic               taken,
  input  busPkg::busDataT    datI,
  input  logic               ack,
  output logic               ready,
  output logic               done,
  output logic               passed,
  output logic               cyc,
  output logic               stb,
  output busPkg::busAddrT    adr
);

  import cascadePkg::*;
  import busPkg::*;

  logic    seqCyc;
  logic    seqStb;
  busAddrT seqAdr;
  logic    seqAck;
  logic    smpCyc;
  logic    smpStb;
  busAddrT smpAdr;
  logic    smpAck;
  logic    rectStart;
  coordT   rect1X0;
  coordT   rect1Y0;
  coordT   rect1X1;
  coordT   rect1Y1;
  coordT   rect2X0;
  coordT   rect2Y0;
  coordT   rect2X1;
  coordT   rect2Y1;
  weightT  weight1;
  weightT  weight2;
  fixedT   classThreshold;
  fixedT   normFactor;
  logic    areaValid;
  fixedT   area1;
  fixedT   area2;
  logic    voteValid;
  logic    votePass;

  cascadeSequencer #(
    .cascadeBase(cascadeBase)
  ) sequencer (
    .clk(clk), .rstN(rstN), .start(start), .varNormIn(varNorm), .taken(taken),
    .busAck(seqAck), .busDat(datI), .areaValid(areaValid), .voteValid(voteValid),
    .votePass(votePass), .ready(ready), .done(done), .passed(passed),
    .busCyc(seqCyc), .busStb(seqStb), .busAdr(seqAdr), .rectStart(rectStart),
    .rect1X0(rect1X0), .rect1Y0(rect1Y0), .rect1X1(rect1X1), .rect1Y1(rect1Y1),
    .rect2X0(rect2X0), .rect2Y0(rect2Y0), .rect2X1(rect2X1), .rect2Y1(rect2Y1),
    .weight1(weight1), .weight2(weight2), .classThreshold(classThreshold),
    .varNorm(normFactor)
  );

  rectangleSampler #(
    .windowBase(windowBase),
    .windowStride(windowStride)
  ) sampler (
    .clk(clk), .rstN(rstN), .rectStart(rectStart),
    .rect1X0(rect1X0), .rect1Y0(rect1Y0), .rect1X1(rect1X1), .rect1Y1(rect1Y1),
    .rect2X0(rect2X0), .rect2Y0(rect2Y0), .rect2X1(rect2X1), .rect2Y1(rect2Y1),
    .busAck(smpAck), .busDat(datI), .busCyc(smpCyc), .busStb(smpStb),
    .busAdr(smpAdr), .areaValid(areaValid), .area1(area1), .area2(area2)
  );

  classifierScorer #(
    .fracBits(fracBits)
  ) scorer (
    .clk(clk), .rstN(rstN), .areaValid(areaValid), .area1(area1), .area2(area2),
    .weight1(weight1), .weight2(weight2), .classThreshold(classThreshold),
    .varNorm(normFactor), .voteValid(voteValid), .votePass(votePass)
  );

  busArbiter arbiter (
    .clk(clk), .rstN(rstN),
    .seqCyc(seqCyc), .seqStb(seqStb), .seqAdr(seqAdr),
    .smpCyc(smpCyc), .smpStb(smpStb), .smpAdr(smpAdr),
    .ack(ack), .seqAck(seqAck), .smpAck(smpAck),
    .cyc(cyc), .stb(stb), .adr(adr)
  );

endmodule

/* haarCascade_sva.sv */
module busProtocolSva (
  input logic              clk,
  input logic              rstN,
  input logic              cyc,
  input logic              stb,
  input busPkg::busAddrT   adr,
  input logic              ack,
  input logic              busy,
  input busPkg::masterIdT  grantId,
  input logic              grantCyc
);

  // a strobe is only valid inside a bus cycle
  stbInsideCyc: assert property (@(posedge clk) disable iff (!rstN)
    stb |-> cyc)
    else $error("stb high while cyc is low");

  // a waiting master keeps its request and its address
  adrHeld: assert property (@(posedge clk) disable iff (!rstN)
    (stb && !ack) |=> (stb && $stable(adr)))
    else $error("adr or stb changed while the read waited for ack");

  // grant moves only after the granted peer drops cyc
  grantHeld: assert property (@(posedge clk) disable iff (!rstN)
    (busy && grantCyc) |=> $stable(grantId))
    else $error("grant switched while the granted cyc was high");

endmodule

bind busArbiter busProtocolSva protocolCheck (
  .clk(clk),
  .rstN(rstN),
  .cyc(cyc),
  .stb(stb),
  .adr(adr),
  .ack(ack),
  .busy(busy),
  .grantId(grantId),
  .grantCyc(grantCyc)
);

/* tbHaarCascade.sv */
module tbHaarCascade;

  import cascadePkg::*;
  import busPkg::*;

  // cascade moved off the default base so the parameter path is exercised
  localparam busAddrT cascadeBase = 16'h0100;
  localparam busAddrT windowBase = windowBaseDefault;
  localparam int windowStride = windowStrideDefault;
  localparam int fracBits = fracBitsDefault;
  localparam int memWords = 65536;
  localparam int numTests = 25;
  localparam int timePerTest = 20000;
  localparam fixedT unityNorm = 32'sh0000_1000;

  logic    clk;
  logic    rstN;
  logic    start;
  fixedT   varNorm;
  logic    taken;
  busDataT datI;
  logic    ack;
  logic    ready;
  logic    done;
  logic    passed;
  logic    cyc;
  logic    stb;
  busAddrT adr;

  logic [31:0] mem [0:memWords-1];
  int          waitPlan [0:255];
  int          seed = 32'h7720_5bc5;
  int          buildAddr;
  int          readCount = 0;

  // expectations handed from the stimulus to the compare process
  string testName;
  logic  expPass;
  int    expReads;
  int    readsBase;
  int    holdPlan;

  int   errorCount = 0;
  int   errorsAtStart = 0;
  int   testCount = 0;
  logic doneSeen = 1'b0;
  int   doneCycles = 0;
  logic heldPassed;
  int   heldReads;
  logic lowNormPassed;

  haarCascade #(
    .cascadeBase(cascadeBase),
    .windowBase(windowBase),
    .windowStride(windowStride),
    .fracBits(fracBits)
  ) DUT (
    .clk(clk), .rstN(rstN), .start(start), .varNorm(varNorm), .taken(taken),
    .datI(datI), .ack(ack), .ready(ready), .done(done), .passed(passed),
    .cyc(cyc), .stb(stb), .adr(adr)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(numTests * timePerTest);
    $display("watchdog: run did not finish within %0d time units", numTests * timePerTest);
    $display("TEST FAILED");
    $finish;
  end

  function automatic int randBelow(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic int randSigned(input int n);
    return $random(seed) % n;
  endfunction

  function automatic int integralAt(input int x, input int y);
    busAddrT a;
    a = busAddrT'(int'(windowBase) + y * windowStride + x);
    return int'(mem[a]);
  endfunction

  function automatic int rectArea(input logic [31:0] word);
    int x0;
    int y0;
    int x1;
    int y1;
    x0 = int'(word[4:0]);
    y0 = int'(word[9:5]);
    x1 = int'(word[14:10]);
    y1 = int'(word[19:15]);
    return integralAt(x1, y1) - integralAt(x1, y0) - integralAt(x0, y1) + integralAt(x0, y0);
  endfunction

  // walks the cascade in memory and returns the decision and the bus reads it takes
  function automatic logic expectedResult(input fixedT normValue, output int reads);
    busAddrT     addr;
    int          s;
    int          c;
    int          stages;
    int          classes;
    int          stageThr;
    int          stageSum;
    int          classThr;
    int          feature;
    longint      scaled;
    logic [31:0] r1;
    logic [31:0] r2;
    addr = cascadeBase;
    stages = int'(mem[addr][7:0]);
    addr = addr + 16'd1;
    reads = 1;
    for (s = 0; s < stages; s++) begin
      stageThr = int'(mem[addr]);
      classes = int'(mem[addr + 16'd1][7:0]);
      addr = addr + 16'd2;
      reads = reads + 2;
      stageSum = 0;
      for (c = 0; c < classes; c++) begin
        classThr = int'(mem[addr]);
        r1 = mem[addr + 16'd1];
        r2 = mem[addr + 16'd2];
        feature = int'($signed(r1[31:20])) * rectArea(r1)
                  + int'($signed(r2[31:20])) * rectArea(r2);
        scaled = (longint'(classThr) * longint'(normValue)) >>> fracBits;
        // pass alpha sits after the fail alpha
        if (feature >= int'(scaled)) begin
          stageSum = stageSum + int'(mem[addr + 16'd4]);
        end else begin
          stageSum = stageSum + int'(mem[addr + 16'd3]);
        end
        addr = addr + 16'd5;
        reads = reads + 5 + 8;
      end
      if (stageSum < stageThr) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic compareValue(input string what, input int got, input int want);
    if (got !== want) begin
      errorCount = errorCount + 1;
      $display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, want);
    end
  endtask

  task automatic fillMemory();
    busAddrT a;
    int      i;
    int      x;
    int      y;
    int      sum;
    for (i = 0; i < memWords; i++) begin
      mem[i] = {16'hc0de, 16'(i)};
    end
    // integral image of a pseudo pixel pattern
    for (y = 0; y < 32; y++) begin
      for (x = 0; x < 32; x++) begin
        a = busAddrT'(int'(windowBase) + y * windowStride + x);
        sum = int'((a * 37 + (a >> 5)) % 256);
        if (x > 0) sum = sum + integralAt(x - 1, y);
        if (y > 0) sum = sum + integralAt(x, y - 1);
        if (x > 0 && y > 0) sum = sum - integralAt(x - 1, y - 1);
        mem[a] = sum;
      end
    end
  endtask

  function automatic logic [31:0] rectWord(input int x0, input int y0, input int x1,
                                           input int y1, input int w);
    return {w[11:0], y1[4:0], x1[4:0], y0[4:0], x0[4:0]};
  endfunction

  task automatic putWord(input logic [31:0] word);
    mem[buildAddr] = word;
    buildAddr = buildAddr + 1;
  endtask

  task automatic putClassifier(input int thr, input logic [31:0] r1, input logic [31:0] r2,
                               input int failVote, input int passVote);
    putWord(thr);
    putWord(r1);
    putWord(r2);
    putWord(failVote);
    putWord(passVote);
  endtask

  // both alphas clear each stage threshold
  task automatic buildTwoStagePass();
    buildAddr = cascadeBase;
    putWord(2);
    putWord(32'h100);
    putWord(1);
    putClassifier(0, rectWord(2, 2, 6, 6, 1), rectWord(8, 8, 12, 12, -1), 32'h100, 32'h200);
    putWord(-5);
    putWord(2);
    putClassifier(32'h40, rectWord(0, 0, 31, 31, 2), rectWord(4, 4, 9, 20, -3), 3, -2);
    putClassifier(-32'h40, rectWord(10, 3, 20, 9, 1), rectWord(1, 1, 5, 5, 1), -2, 1);
  endtask

  // no alpha reaches the first stage threshold
  task automatic buildEarlyReject();
    buildAddr = cascadeBase;
    putWord(2);
    putWord(32'h300);
    putWord(1);
    putClassifier(0, rectWord(1, 2, 9, 7, 5), rectWord(3, 3, 4, 11, -7), 32'h10, 32'h20);
    putWord(0);
    putWord(1);
    putClassifier(0, rectWord(0, 0, 8, 8, 1), rectWord(0, 0, 2, 2, 1), 1, 2);
  endtask

  // single vote decides and rect 2 is empty so the feature is one positive area
  task automatic buildNormFlip();
    buildAddr = cascadeBase;
    putWord(1);
    putWord(1);
    putWord(1);
    putClassifier(1, rectWord(3, 3, 7, 7, 1), rectWord(0, 0, 0, 0, 0), 0, 1);
  endtask

  task automatic buildRandomCascade();
    int s;
    int c;
    int stages;
    int classes;
    buildAddr = cascadeBase;
    stages = 1 + randBelow(3);
    putWord(stages);
    for (s = 0; s < stages; s++) begin
      classes = 1 + randBelow(3);
      putWord(randSigned(512));
      putWord(classes);
      for (c = 0; c < classes; c++) begin
        putClassifier(randSigned(1 << 20),
                      rectWord(randBelow(32), randBelow(32), randBelow(32), randBelow(32),
                               randSigned(2048)),
                      rectWord(randBelow(32), randBelow(32), randBelow(32), randBelow(32),
                               randSigned(2048)),
                      randSigned(256), randSigned(256));
      end
    end
  endtask

  task automatic runCascade(input string name, input fixedT normValue, input int holdCycles);
    int target;
    target = testCount + 1;
    testName = name;
    holdPlan = holdCycles;
    expPass = expectedResult(normValue, expReads);
    readsBase = readCount;
    while (!ready) @(negedge clk);
    start = 1'b1;
    varNorm = normValue;
    @(negedge clk);
    start = 1'b0;
    while (!done) @(negedge clk);
    repeat (holdCycles) @(negedge clk);
    taken = 1'b1;
    @(negedge clk);
    taken = 1'b0;
    while (testCount != target) @(negedge clk);
  endtask

  // memory with 0 to 3 wait states per read
  initial begin
    int   reqIndex;
    int   waitLeft;
    logic pending;
    ack = 1'b0;
    datI = '0;
    reqIndex = 0;
    waitLeft = 0;
    pending = 1'b0;
    forever begin
      @(negedge clk);
      ack = 1'b0;
      if (!(cyc && stb)) begin
        pending = 1'b0;
      end else begin
        if (!pending) begin
          pending = 1'b1;
          waitLeft = waitPlan[reqIndex % 256];
          reqIndex = reqIndex + 1;
        end
        if (waitLeft == 0) begin
          ack = 1'b1;
          datI = mem[adr];
          pending = 1'b0;
        end else begin
          waitLeft = waitLeft - 1;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (ack && cyc && stb) begin
      readCount <= readCount + 1;
    end
  end

  // result compare and then hold checks until taken releases the engine
  always @(negedge clk) begin
    if (rstN) begin
      if (done && !doneSeen) begin
        doneSeen = 1'b1;
        doneCycles = 1;
        heldPassed = passed;
        heldReads = readCount;
        compareValue("passed", int'(passed), int'(expPass));
        compareValue("bus reads", readCount - readsBase, expReads);
      end else if (done) begin
        doneCycles = doneCycles + 1;
        compareValue("passed while done", int'(passed), int'(heldPassed));
        compareValue("bus reads while done", readCount, heldReads);
        compareValue("stb while done", int'(stb), 0);
        compareValue("cyc while done", int'(cyc), 0);
      end else if (doneSeen) begin
        doneSeen = 1'b0;
        compareValue("done cycles until taken", doneCycles, holdPlan + 1);
        compareValue("ready after taken", int'(ready), 1);
        testCount = testCount + 1;
        $display("test %0d %s: %s, %0d reads", testCount, testName,
                 (errorCount == errorsAtStart) ? "matched" : "mismatch",
                 readCount - readsBase);
        errorsAtStart = errorCount;
      end
    end
  end

  initial begin
    int i;
    rstN = 1'b0;
    start = 1'b0;
    taken = 1'b0;
    varNorm = '0;
    for (i = 0; i < 256; i++) begin
      waitPlan[i] = randBelow(4);
    end
    fillMemory();
    repeat (3) @(negedge clk);
    rstN = 1'b1;
    @(negedge clk);

    buildTwoStagePass();
    runCascade("two stages pass", unityNorm, 0);
    buildEarlyReject();
    runCascade("reject in stage one", unityNorm, 0);
    // threshold scales to -256 and then to 2^18
    buildNormFlip();
    runCascade("low norm factor", -32'sh0010_0000, 0);
    lowNormPassed = heldPassed;
    runCascade("high norm factor", 32'sh4000_0000, 0);
    compareValue("norm factor flips the result", int'(heldPassed), int'(!lowNormPassed));
    buildTwoStagePass();
    runCascade("result held until taken", unityNorm, 5 + randBelow(20));
    for (i = 0; i < 20; i++) begin
      buildRandomCascade();
      runCascade($sformatf("random cascade %0d", i + 1), fixedT'(2048 + randBelow(8192)), 0);
    end

    $display("%0d tests, %0d errors", testCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* haarCascade.f */
cascadePkg.sv
busPkg.sv
busArbiter.sv
cascadeSequencer.sv
rectangleSampler.sv
classifierScorer.sv
haarCascade.sv
haarCascade_sva.sv
tbHaarCascade.sv

/* run.sh */
#!/bin/sh
# Build the Haar cascade testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tbHaarCascade -f haarCascade.f \
  --Mdir obj_dir -o simHaarCascade
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/simHaarCascade)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1
